/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -sv -f vlog.f --top-module tb_soc_io -o sim_soc_io
./obj_dir/sim_soc_io > sim.log
cat sim.log
if grep -q "=== FAIL ===" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* tb/soc_io_trace.txt */
# op addr_or_count wdata instr exp_data exp_fault (hex); R read, W write, T timer step
# X writes a random word to addr and reads it back; T expects mtime_o in exp_data
R 1000000c 0 0 000401b2 0
R 10000010 0 0 00020001 0
R 10000014 0 0 00003200 0
R 10000018 0 0 02000000 0
W 1000000c 00080020 0 0 0
R 1000000c 0 0 00080020 0
W 10000010 00030001 0 0 0
R 10000010 0 0 00030001 0
W 10000014 000000ff 0 0 0
R 10000014 0 0 00000100 0
W 10000014 00000100 0 0 0
R 10000014 0 0 00000100 0
W 10000014 12345678 0 0 0
R 10000014 0 0 00005678 0
R 10000020 0 0 00000000 0
W 10000020 deadbeef 0 0 0
R 30000000 0 0 00000000 1
W 30000000 00000001 0 0 1
R 1000000c 0 1 00000000 1
T 1 0 0 1 0
T 2 0 0 2 0
T 3 0 0 3 0
W 10000010 00030004 0 0 0
R 10000010 0 0 00030004 0
T a 0 0 0 0
T b 0 0 0 0
T c 0 0 0 0
T d 0 0 0 0
T e 0 0 1 0
T f 0 0 1 0
T 10 0 0 1 0
T 11 0 0 1 0
T 12 0 0 2 0
X 1000000c 0 0 0 0
X 10000010 0 0 0 0

/* tb/tb_soc_io.sv */
// run from the project root so the trace path resolves; one request in flight, no back-pressure.
`timescale 1ns/100ps

module tb_soc_io;
  import soc_map_pkg::*;
  import soc_clk_pkg::*;

  localparam string TRACE_FILE = "tb/soc_io_trace.txt";

  logic  clk;
  logic  resetn;
  logic  bus_valid_i;
  word_t bus_addr_i;
  strb_t bus_wstrb_i;
  word_t bus_wdata_i;
  logic  bus_instr_i;
  logic  bus_ready_o;
  word_t bus_rdata_o;
  logic  bus_fault_o;
  time_t timer_counter_i;
  div_t  uart_div_o;
  div_t  spi0_div_o;
  div_t  spi1_div_o;
  q8_8_t sysclk_mhz_o;
  time_t mtime_o;

  int          value_errs = 0;
  int          other_errs = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  logic [31:0] rnd_state = 32'hbd4d;

  soc_io DUT (.*);

  always #4 clk = ~clk; // 8 ns period.

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: the run went past %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      value_errs++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_div(input string name, input div_t exp, input div_t act);
    if (act !== exp) begin
      value_errs++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_q88(input string name, input q8_8_t exp, input q8_8_t act);
    if (act !== exp) begin
      value_errs++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_time(input string name, input time_t exp, input time_t act);
    if (act !== exp) begin
      value_errs++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errs++;
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
    end
  endtask

  // rate fields are the halves of the word just read.
  task automatic check_rates(input string name, input word_t addr, input word_t word);
    if (addr == DIV0_ADDR) begin
      check_div({name, " uart"}, word[15:0], uart_div_o);
      check_div({name, " spi0"}, word[31:16], spi0_div_o);
    end else if (addr == DIV1_ADDR) begin
      check_div({name, " spi1"}, word[31:16], spi1_div_o);
    end else if (addr == CPU_FREQ_ADDR) begin
      check_q88({name, " sysclk"}, word[15:0], sysclk_mhz_o);
    end
  endtask

  task automatic bus_op(input string name, input word_t addr, input word_t wdata, input logic wr,
                        input logic instr, input word_t exp_data, input logic exp_fault);
    logic  ok;
    word_t rdata;
    logic  fault;
    @(posedge clk);
    #1;
    // the previous ready pulse is over, so the bus is idle here.
    check_bit({name, " idle ready"}, 1'b0, bus_ready_o);
    check_word({name, " idle rdata"}, 32'h0, bus_rdata_o);
    bus_valid_i = 1'b1;
    bus_addr_i  = addr;
    bus_wdata_i = wdata;
    bus_wstrb_i = wr ? 4'hf : 4'h0;
    bus_instr_i = instr;
    @(posedge clk);
    #1;
    ok    = bus_ready_o; // ready is due exactly one cycle after valid.
    rdata = bus_rdata_o;
    fault = bus_fault_o;
    bus_valid_i = 1'b0;
    bus_wstrb_i = 4'h0;
    bus_instr_i = 1'b0;
    if (!ok) begin
      other_errs++;
      $display("%s: ready did not come one cycle after valid", name);
    end else begin
      check_bit({name, " fault"}, exp_fault, fault);
      if (!wr || exp_fault) begin
        check_word({name, " rdata"}, exp_data, rdata);
      end
      if (!wr && !exp_fault) begin
        check_rates(name, addr, exp_data);
      end
    end
  endtask

  task automatic timer_step(input string name, input time_t value, input time_t exp_mtime);
    @(posedge clk);
    #1;
    timer_counter_i = value;
    @(posedge clk);
    #1;
    check_time(name, exp_mtime, mtime_o);
  endtask

  task automatic run_trace(input int fd);
    int               code;
    int               op_no;
    logic [7:0]       op;
    time_t            arg;
    word_t            wdata;
    logic             instr;
    time_t            exp_data;
    logic             exp_fault;
    logic [8*128-1:0] rest;
    string            name;
    op_no = 0;
    code  = $fscanf(fd, "%s", op);
    while (code == 1) begin
      if (op == "#") begin
        code = $fgets(rest, fd); // skip the column notes.
      end else begin
        code = $fscanf(fd, "%h %h %h %h %h", arg, wdata, instr, exp_data, exp_fault);
        op_no++;
        name = $sformatf("op %0d %c %h", op_no, op, arg[31:0]);
        if (code != 5) begin
          other_errs++;
          $display("%s: the trace line has missing fields", name);
        end else begin
          case (op)
            "R": bus_op(name, arg[31:0], wdata, 1'b0, instr, exp_data[31:0], exp_fault);
            "W": bus_op(name, arg[31:0], wdata, 1'b1, instr, exp_data[31:0], exp_fault);
            "T": timer_step(name, arg, exp_data);
            "X": begin
              rnd_state = xorshift32(rnd_state);
              bus_op(name, arg[31:0], rnd_state, 1'b1, 1'b0, 32'h0, 1'b0);
              bus_op(name, arg[31:0], 32'h0, 1'b0, 1'b0, rnd_state, 1'b0);
            end
            default: begin
              other_errs++;
              $display("%s: unknown operation in the trace", name);
            end
          endcase
        end
      end
      code = $fscanf(fd, "%s", op);
    end
  endtask

  initial begin
    int               fd;
    int               n_lines;
    logic [8*128-1:0] line;
    clk             = 1'b0;
    resetn          = 1'b0;
    bus_valid_i     = 1'b0;
    bus_addr_i      = '0;
    bus_wstrb_i     = '0;
    bus_wdata_i     = '0;
    bus_instr_i     = 1'b0;
    timer_counter_i = '0;
    n_lines         = 0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the trace file %s", TRACE_FILE);
      $display("=== FAIL ===");
      $finish;
    end else begin
      while ($fgets(line, fd) > 0) begin
        n_lines++;
      end
      $fclose(fd);
      cycle_limit = 4 * (n_lines * 3);
      repeat (4) @(posedge clk);
      #1;
      resetn = 1'b1;
      check_div("reset uart", UART_DIV_RST, uart_div_o);
      check_div("reset spi0", SPI0_DIV_RST, spi0_div_o);
      check_div("reset spi1", SPI1_DIV_RST, spi1_div_o);
      check_q88("reset sysclk", FREQ_RST, sysclk_mhz_o);
      check_time("reset mtime", 64'd0, mtime_o);
      check_bit("reset ready", 1'b0, bus_ready_o);
      fd = $fopen(TRACE_FILE, "r");
      run_trace(fd);
      $fclose(fd);
      $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
      $finish;
    end
  end

endmodule

/* verilog/bus_decode.sv */
// combinational decode; selects stay low while the target's ready is pending, sdram and flash select nothing.
`timescale 1ns/100ps

module bus_decode (
  input  logic               bus_valid_i,
  input  soc_map_pkg::word_t bus_addr_i,
  input  soc_map_pkg::strb_t bus_wstrb_i,
  input  logic               bus_instr_i,
  input  logic [4:0]         busy_i, // {resp, mem, freq, div1, div0}.
  output logic               sel_div0_o,
  output logic               sel_div1_o,
  output logic               sel_freq_o,
  output logic               sel_mem_o,
  output logic               sel_unmatched_o,
  output logic               sel_fault_o,
  output logic               wr_o
);
  import soc_map_pkg::*;

  logic is_io;
  logic is_sdram;
  logic is_flash;
  logic fault;
  logic hit_div0;
  logic hit_div1;
  logic hit_freq;
  logic hit_mem;
  logic hit_any;

  assign is_io = ((bus_addr_i >= IO_LO) && (bus_addr_i <= IO_HI)) ||
                 (bus_addr_i[31:24] == CLINT_HI) || (bus_addr_i[31:24] == PLIC_HI);
  assign is_sdram = (bus_addr_i >= SDRAM_LO) && (bus_addr_i < SDRAM_HI);
  assign is_flash = (bus_addr_i >= FLASH_LO) && (bus_addr_i < FLASH_HI);

  // fetches only from memory, data from memory or i/o.
  assign fault = bus_instr_i ? !(is_sdram || is_flash) : !(is_io || is_sdram || is_flash);

  assign hit_div0 = !fault && (bus_addr_i == DIV0_ADDR);
  assign hit_div1 = !fault && (bus_addr_i == DIV1_ADDR);
  assign hit_freq = !fault && (bus_addr_i == CPU_FREQ_ADDR);
  assign hit_mem  = !fault && (bus_addr_i == MEM_SIZE_ADDR);
  assign hit_any  = hit_div0 || hit_div1 || hit_freq || hit_mem;

  assign sel_div0_o = bus_valid_i && hit_div0 && !busy_i[0];
  assign sel_div1_o = bus_valid_i && hit_div1 && !busy_i[1];
  assign sel_freq_o = bus_valid_i && hit_freq && !busy_i[2];
  assign sel_mem_o  = bus_valid_i && hit_mem && !busy_i[3];

  assign sel_unmatched_o = bus_valid_i && is_io && !fault && !hit_any && !busy_i[4];
  assign sel_fault_o     = bus_valid_i && fault && !busy_i[4];

  assign wr_o = |bus_wstrb_i;

endmodule

/* verilog/clock_div_regs.sv */
// full-word writes only, strobes are not applied per byte; a zero divider is passed through as written.
`timescale 1ns/100ps

module clock_div_regs (
  input  logic               clk,
  input  logic               resetn,
  input  logic               sel0_i,
  input  logic               sel1_i,
  input  logic               wr_i,
  input  soc_map_pkg::word_t wdata_i,
  output soc_map_pkg::word_t rdata_o,
  output logic               ready_o,
  output logic [1:0]         busy_o,
  output soc_clk_pkg::div_t  uart_div_o,
  output soc_clk_pkg::div_t  spi0_div_o,
  output soc_clk_pkg::div_t  spi1_div_o,
  output soc_clk_pkg::div_t  mtime_div_o
);
  import soc_map_pkg::*;
  import soc_clk_pkg::*;

  word_t div0_q;
  word_t div1_q;
  logic  ready0;
  logic  ready1;

  mmio_reg #(.data_t(word_t), .RESET_VAL(DIV0_RST)) u_div0 (
    .clk     (clk),
    .resetn  (resetn),
    .sel_i   (sel0_i),
    .wr_i    (wr_i),
    .wdata_i (wdata_i),
    .q_o     (div0_q),
    .ready_o (ready0)
  );

  mmio_reg #(.data_t(word_t), .RESET_VAL(DIV1_RST)) u_div1 (
    .clk     (clk),
    .resetn  (resetn),
    .sel_i   (sel1_i),
    .wr_i    (wr_i),
    .wdata_i (wdata_i),
    .q_o     (div1_q),
    .ready_o (ready1)
  );

  assign rdata_o = ready0 ? div0_q : (ready1 ? div1_q : '0);
  assign ready_o = ready0 || ready1;
  assign busy_o  = {ready1, ready0};

  assign spi0_div_o  = div0_q[31:16];
  assign uart_div_o  = div0_q[15:0];
  assign spi1_div_o  = div1_q[31:16];
  assign mtime_div_o = div1_q[15:0]; // microseconds per mtime tick.

endmodule

/* verilog/mmio_reg.sv */
// one register; a select without wr_i is a read, and ready follows every select by one cycle.
`timescale 1ns/100ps

module mmio_reg #(
  parameter type   data_t    = soc_map_pkg::word_t,
  parameter data_t RESET_VAL = '0
) (
  input  logic  clk,
  input  logic  resetn,
  input  logic  sel_i,
  input  logic  wr_i,
  input  data_t wdata_i,
  output data_t q_o,
  output logic  ready_o
);

  data_t value_q;
  logic  ready_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      value_q <= RESET_VAL;
      ready_q <= 1'b0;
    end else begin
      ready_q <= sel_i; // one-cycle pulse, decode holds sel low meanwhile.
      if (sel_i && wr_i) begin
        value_q <= wdata_i;
      end
    end
  end

  assign q_o     = value_q;
  assign ready_o = ready_q;

endmodule

/* verilog/mtime_prescaler.sv */
// a divisor of 0 counts as 1; the divided count runs from reset and does not follow the raw counter value.
`timescale 1ns/100ps

module mtime_prescaler (
  input  logic               clk,
  input  logic               resetn,
  input  soc_clk_pkg::time_t timer_counter_i,
  input  soc_clk_pkg::div_t  mtime_div_i,
  output soc_clk_pkg::time_t mtime_o
);
  import soc_clk_pkg::*;

  time_t prev_cnt;
  time_t mtime_div;
  div_t  presc;
  div_t  div_lat;
  div_t  div_safe;
  logic  tick;

  assign tick     = (timer_counter_i != prev_cnt);
  assign div_safe = (mtime_div_i == 16'd0) ? 16'd1 : mtime_div_i;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      prev_cnt  <= '0;
      presc     <= '0;
      div_lat   <= 16'd1;
      mtime_div <= '0;
    end else if (tick) begin
      prev_cnt <= timer_counter_i;
      if (div_lat != div_safe) begin
        div_lat <= div_safe; // new divisor, restart the prescaler.
        presc   <= '0;
      end else if (div_lat != 16'd1) begin
        if (presc == div_lat - 16'd1) begin
          presc     <= '0;
          mtime_div <= mtime_div + 64'd1;
        end else begin
          presc <= presc + 16'd1;
        end
      end
    end
  end

  // undivided timer passes straight through.
  assign mtime_o = (div_lat == 16'd1) ? timer_counter_i : mtime_div;

endmodule

/* verilog/resp_mux.sv */
// assumes one request in flight, so at most one ready is high; the fault only shows when no target answered.
`timescale 1ns/100ps

module resp_mux (
  input  logic               clk,
  input  logic               resetn,
  input  logic               sys_ready_i,
  input  soc_map_pkg::word_t sys_rdata_i,
  input  logic               div_ready_i,
  input  soc_map_pkg::word_t div_rdata_i,
  input  logic               sel_unmatched_i,
  input  logic               sel_fault_i,
  output logic               busy_o,
  output logic               bus_ready_o,
  output soc_map_pkg::word_t bus_rdata_o,
  output logic               bus_fault_o
);

  logic unmatched_q;
  logic fault_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      unmatched_q <= 1'b0;
      fault_q     <= 1'b0;
    end else begin
      unmatched_q <= sel_unmatched_i;
      fault_q     <= sel_fault_i;
    end
  end

  assign busy_o = unmatched_q || fault_q;

  always_comb begin
    bus_ready_o = 1'b0;
    bus_rdata_o = '0;
    bus_fault_o = 1'b0;
    if (sys_ready_i) begin
      bus_ready_o = 1'b1;
      bus_rdata_o = sys_rdata_i;
    end else if (div_ready_i) begin
      bus_ready_o = 1'b1;
      bus_rdata_o = div_rdata_i;
    end else if (unmatched_q) begin
      bus_ready_o = 1'b1; // empty i/o slot reads as zero.
    end else if (fault_q) begin
      bus_ready_o = 1'b1;
      bus_fault_o = 1'b1;
    end
  end

endmodule

/* verilog/soc_clk_pkg.sv */
// divider defaults assume a 50 MHz system clock and a 1 MHz timer counter; a divider above 65535 is not caught.
package soc_clk_pkg;

  localparam int SYS_CLK_HZ = 50_000_000;

  // target rates behind the reset dividers
  localparam int UART_BAUD     = 115_200;
  localparam int SPI0_SCLK_HZ  = 12_000_000;
  localparam int SPI1_SCLK_HZ  = 24_000_000;
  localparam int US_TICK_HZ    = 1_000_000; // rate of the incoming timer counter.
  localparam int MTIME_TICK_HZ = 1_000_000; // wanted mtime rate.

  typedef logic [15:0] div_t;  // clock divider.
  typedef logic [15:0] q8_8_t; // mhz, 8 integer and 8 fraction bits.
  typedef logic [63:0] time_t; // timer value.

  // rounded integer division of source rate by target rate
  localparam div_t UART_DIV_RST  = div_t'((SYS_CLK_HZ + UART_BAUD / 2) / UART_BAUD);
  localparam div_t SPI0_DIV_RST  = div_t'((SYS_CLK_HZ + SPI0_SCLK_HZ / 2) / SPI0_SCLK_HZ);
  localparam div_t SPI1_DIV_RST  = div_t'((SYS_CLK_HZ + SPI1_SCLK_HZ / 2) / SPI1_SCLK_HZ);
  localparam div_t MTIME_DIV_RST = div_t'((US_TICK_HZ + MTIME_TICK_HZ / 2) / MTIME_TICK_HZ);

  localparam soc_map_pkg::word_t DIV0_RST = {SPI0_DIV_RST, UART_DIV_RST};
  localparam soc_map_pkg::word_t DIV1_RST = {SPI1_DIV_RST, MTIME_DIV_RST};

  // whole mhz in the upper byte, rounded fraction in the lower.
  localparam q8_8_t FREQ_RST = q8_8_t'(((SYS_CLK_HZ / 1_000_000) * 256) +
                                       (((SYS_CLK_HZ % 1_000_000) * 256 + 500_000) / 1_000_000));
  localparam q8_8_t FREQ_MIN = 16'h0100; // 1.0 mhz floor.

endpackage

/* verilog/soc_io.sv */
// every answered request gets ready one cycle after valid; sdram and flash requests are never answered.
`timescale 1ns/100ps

module soc_io (
  input  logic               clk,
  input  logic               resetn,
  input  logic               bus_valid_i,
  input  soc_map_pkg::word_t bus_addr_i,
  input  soc_map_pkg::strb_t bus_wstrb_i,
  input  soc_map_pkg::word_t bus_wdata_i,
  input  logic               bus_instr_i,
  output logic               bus_ready_o,
  output soc_map_pkg::word_t bus_rdata_o,
  output logic               bus_fault_o,
  input  soc_clk_pkg::time_t timer_counter_i,
  output soc_clk_pkg::div_t  uart_div_o,
  output soc_clk_pkg::div_t  spi0_div_o,
  output soc_clk_pkg::div_t  spi1_div_o,
  output soc_clk_pkg::q8_8_t sysclk_mhz_o,
  output soc_clk_pkg::time_t mtime_o
);
  import soc_map_pkg::*;
  import soc_clk_pkg::*;

  logic       sel_div0;
  logic       sel_div1;
  logic       sel_freq;
  logic       sel_mem;
  logic       sel_unmatched;
  logic       sel_fault;
  logic       wr;
  logic [1:0] div_busy;
  logic [1:0] sys_busy;
  logic       resp_busy;
  logic       div_ready;
  logic       sys_ready;
  word_t      div_rdata;
  word_t      sys_rdata;
  div_t       mtime_div;

  bus_decode u_decode (
    .bus_valid_i     (bus_valid_i),
    .bus_addr_i      (bus_addr_i),
    .bus_wstrb_i     (bus_wstrb_i),
    .bus_instr_i     (bus_instr_i),
    .busy_i          ({resp_busy, sys_busy, div_busy}),
    .sel_div0_o      (sel_div0),
    .sel_div1_o      (sel_div1),
    .sel_freq_o      (sel_freq),
    .sel_mem_o       (sel_mem),
    .sel_unmatched_o (sel_unmatched),
    .sel_fault_o     (sel_fault),
    .wr_o            (wr)
  );

  clock_div_regs u_div (
    .clk         (clk),
    .resetn      (resetn),
    .sel0_i      (sel_div0),
    .sel1_i      (sel_div1),
    .wr_i        (wr),
    .wdata_i     (bus_wdata_i),
    .rdata_o     (div_rdata),
    .ready_o     (div_ready),
    .busy_o      (div_busy),
    .uart_div_o  (uart_div_o),
    .spi0_div_o  (spi0_div_o),
    .spi1_div_o  (spi1_div_o),
    .mtime_div_o (mtime_div)
  );

  sysinfo_regs u_sysinfo (
    .clk          (clk),
    .resetn       (resetn),
    .sel_freq_i   (sel_freq),
    .sel_mem_i    (sel_mem),
    .wr_i         (wr),
    .wdata_i      (bus_wdata_i),
    .rdata_o      (sys_rdata),
    .ready_o      (sys_ready),
    .busy_o       (sys_busy),
    .sysclk_mhz_o (sysclk_mhz_o)
  );

  mtime_prescaler u_mtime (
    .clk             (clk),
    .resetn          (resetn),
    .timer_counter_i (timer_counter_i),
    .mtime_div_i     (mtime_div),
    .mtime_o         (mtime_o)
  );

  resp_mux u_resp (
    .clk             (clk),
    .resetn          (resetn),
    .sys_ready_i     (sys_ready),
    .sys_rdata_i     (sys_rdata),
    .div_ready_i     (div_ready),
    .div_rdata_i     (div_rdata),
    .sel_unmatched_i (sel_unmatched),
    .sel_fault_i     (sel_fault),
    .busy_o          (resp_busy),
    .bus_ready_o     (bus_ready_o),
    .bus_rdata_o     (bus_rdata_o),
    .bus_fault_o     (bus_fault_o)
  );

endmodule

/* verilog/soc_map_pkg.sv */
// byte addresses throughout; the sdram and flash ranges exist only for the fault rule, nothing answers there.
package soc_map_pkg;

  typedef logic [31:0] word_t; // bus address or data word.
  typedef logic [3:0]  strb_t; // byte write strobe, nonzero means write.

  // system-control registers, one word each
  localparam word_t DIV0_ADDR     = 32'h1000_000C; // spi0 | uart divider.
  localparam word_t DIV1_ADDR     = 32'h1000_0010; // spi1 | mtime divider.
  localparam word_t CPU_FREQ_ADDR = 32'h1000_0014; // q8.8 mhz.
  localparam word_t MEM_SIZE_ADDR = 32'h1000_0018; // read only.

  // i/o window, both bounds inclusive
  localparam word_t IO_LO = 32'h1000_0000;
  localparam word_t IO_HI = 32'h1200_0000;

  // top-byte windows still counted as i/o.
  localparam logic [7:0] CLINT_HI = 8'h02;
  localparam logic [7:0] PLIC_HI  = 8'h0C;

  localparam word_t SDRAM_SIZE = 32'h0200_0000;

  // memory ranges, upper bound exclusive
  localparam word_t SDRAM_LO = 32'h8000_0000;
  localparam word_t SDRAM_HI = SDRAM_LO + SDRAM_SIZE;
  localparam word_t FLASH_LO = 32'h2000_0000;
  localparam word_t FLASH_HI = 32'h2400_0000; // 64 MiB of nor flash.

endpackage

/* verilog/sysinfo_regs.sv */
// only the low 16 bits of a frequency write are kept; writes to the memory size are acknowledged and dropped.
`timescale 1ns/100ps

module sysinfo_regs (
  input  logic               clk,
  input  logic               resetn,
  input  logic               sel_freq_i,
  input  logic               sel_mem_i,
  input  logic               wr_i,
  input  soc_map_pkg::word_t wdata_i,
  output soc_map_pkg::word_t rdata_o,
  output logic               ready_o,
  output logic [1:0]         busy_o,
  output soc_clk_pkg::q8_8_t sysclk_mhz_o
);
  import soc_map_pkg::*;
  import soc_clk_pkg::*;

  q8_8_t freq_wdata;
  q8_8_t freq_q;
  logic  freq_ready;
  logic  mem_ready;

  // nothing below 1.0 mhz, the core divides by this.
  assign freq_wdata = (wdata_i[15:0] < FREQ_MIN) ? FREQ_MIN : wdata_i[15:0];

  mmio_reg #(.data_t(q8_8_t), .RESET_VAL(FREQ_RST)) u_freq (
    .clk     (clk),
    .resetn  (resetn),
    .sel_i   (sel_freq_i),
    .wr_i    (wr_i),
    .wdata_i (freq_wdata),
    .q_o     (freq_q),
    .ready_o (freq_ready)
  );

  always_ff @(posedge clk) begin
    if (!resetn) begin
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= sel_mem_i;
    end
  end

  always_comb begin
    rdata_o = '0;
    if (freq_ready) begin
      rdata_o = {16'h0000, freq_q};
    end else if (mem_ready) begin
      rdata_o = SDRAM_SIZE;
    end
  end

  assign ready_o      = freq_ready || mem_ready;
  assign busy_o       = {mem_ready, freq_ready};
  assign sysclk_mhz_o = freq_q;

endmodule

/* vlog.f */
verilog/soc_map_pkg.sv
verilog/soc_clk_pkg.sv
verilog/bus_decode.sv
verilog/mmio_reg.sv
verilog/clock_div_regs.sv
verilog/sysinfo_regs.sv
verilog/mtime_prescaler.sv
verilog/resp_mux.sv
verilog/soc_io.sv
tb/tb_soc_io.sv
